// ==== src/ntm_inverter_pkg.sv ====
/*
 * Shared definitions of the modular inverter
 *   Data word width and common word constants
 *   Iteration bound of the scalar inverter and its counter width
 *   State encoding of the vector sequencer
 */

`default_nettype none

package ntm_inverter_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data, modulus, length and result words
  localparam int data_size = 32;

  // Safety stop of the reduction loop
  localparam int iter_limit = 2 * data_size;
  localparam int iter_width = $clog2(iter_limit + 1);

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam logic [data_size-1:0] word_zero = '0;
  localparam logic [data_size-1:0] word_one  = 1;

  //////////////////////////////////////////////////////////////////////
  // Sequencer states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    starter_state = 2'd0,   // Wait for START
    input_state   = 2'd1,   // Wait for next element
    ender_state   = 2'd2    // Wait for scalar result
  } vector_state_t;

endpackage

`default_nettype wire

// ==== src/ntm_scalar_inverter.sv ====
/*
 * Iterative modular inverter for one element
 *   Binary extended Euclid, one reduction step per cycle
 *   Load cycle, up to iter_limit iterations, one correction cycle
 *   Returns zero for a non-invertible or zero operand
 */

`timescale 1ns/10ps
`default_nettype none

module ntm_scalar_inverter
  import ntm_inverter_pkg::*;
(
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 start,
  input  wire [data_size-1:0] modulo_in,
  input  wire [data_size-1:0] data_in,
  output logic                ready,
  output logic [data_size-1:0] data_out
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Control
  logic                  busy;
  logic                  corr;
  logic                  stop;
  logic [iter_width-1:0] iter_cnt;

  // Datapath
  // Invariants x1*a = u and x2*a = v, both mod m
  logic [data_size-1:0] u;
  logic [data_size-1:0] v;
  logic [data_size-1:0] x1;
  logic [data_size-1:0] x2;
  logic [data_size-1:0] m;

  // Correction
  logic [data_size-1:0] sel_coef;
  logic [data_size-1:0] fixed_coef;
  logic                 invertible;

  //////////////////////////////////////////////////////////////////////
  // Coefficient arithmetic
  //////////////////////////////////////////////////////////////////////

  // Division by two mod m, m odd
  function automatic logic [data_size-1:0] mod_half(
    input logic [data_size-1:0] x,
    input logic [data_size-1:0] md
  );
    logic [data_size:0] sum;
    sum = {1'b0, x} + {1'b0, md};
    // Odd coefficient made even by adding the modulus
    if (x[0]) begin
      return sum[data_size:1];
    end
    return x >> 1;
  endfunction

  // Subtraction mod m, both operands below m
  function automatic logic [data_size-1:0] mod_sub(
    input logic [data_size-1:0] a,
    input logic [data_size-1:0] b,
    input logic [data_size-1:0] md
  );
    if (a >= b) begin
      return a - b;
    end
    // Wrap around, stays below m
    return a + (md - b);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Loop exit
  //////////////////////////////////////////////////////////////////////

  // One reached, zero reached or iterations spent
  assign stop = (u == word_one) || (v == word_one) ||
                (u == word_zero) || (v == word_zero) ||
                (iter_cnt == iter_width'(iter_limit));

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      corr     <= 1'b0;
      ready    <= 1'b0;
      iter_cnt <= '0;
    end else begin
      // Pulses by default
      corr  <= 1'b0;
      ready <= corr;
      if (start) begin
        // Load cycle
        busy     <= 1'b1;
        iter_cnt <= '0;
      end else if (busy) begin
        if (stop) begin
          busy <= 1'b0;
          corr <= 1'b1;
        end else begin
          iter_cnt <= iter_cnt + iter_width'(1);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reduction datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      u  <= data_in;
      v  <= modulo_in;
      x1 <= word_one;
      x2 <= word_zero;
      m  <= modulo_in;
    end else if (busy && !stop) begin
      if (!u[0]) begin
        // Even u
        u  <= u >> 1;
        x1 <= mod_half(x1, m);
      end else if (!v[0]) begin
        // Even v
        v  <= v >> 1;
        x2 <= mod_half(x2, m);
      end else if (u >= v) begin
        // Both odd, difference is even so halve at once
        u  <= (u - v) >> 1;
        x1 <= mod_half(mod_sub(x1, x2, m), m);
      end else begin
        v  <= (v - u) >> 1;
        x2 <= mod_half(mod_sub(x2, x1, m), m);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Correction
  //////////////////////////////////////////////////////////////////////

  // Coefficient of the side that reached one
  assign invertible = (u == word_one) || (v == word_one);
  assign sel_coef   = (u == word_one) ? x1 : x2;
  assign fixed_coef = (sel_coef >= m) ? sel_coef - m : sel_coef;

  // Result held until next start
  always_ff @(posedge CLK) begin
    if (corr) begin
      data_out <= invertible ? fixed_coef : word_zero;
    end
  end

endmodule

`default_nettype wire

// ==== src/ntm_vector_inverter.sv ====
/*
 * Vector sequencer of the modular inverter
 *   Three-state FSM over the vector elements
 *   Element and modulus registers feeding the scalar inverter
 *   Registered result strobe and end-of-vector READY
 */

`timescale 1ns/10ps
`default_nettype none

module ntm_vector_inverter
  import ntm_inverter_pkg::*;
(
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire  [data_size-1:0] SIZE_IN,
  input  wire                  DATA_IN_ENABLE,
  input  wire  [data_size-1:0] MODULO_IN,
  input  wire  [data_size-1:0] DATA_IN,
  output logic                 READY,
  output logic                 DATA_OUT_ENABLE,
  output logic [data_size-1:0] DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  vector_state_t state;

  // Element counting
  logic [data_size-1:0] index_loop;
  logic [data_size-1:0] last_index;

  // Scalar inverter link
  logic                 start_scalar;
  logic                 ready_scalar;
  logic [data_size-1:0] modulo_scalar;
  logic [data_size-1:0] data_scalar;
  logic [data_size-1:0] result_scalar;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= starter_state;
      index_loop      <= word_zero;
      last_index      <= word_zero;
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= word_zero;
    end else begin
      // Strobes last one cycle
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        starter_state: begin
          if (START) begin
            // Zero length runs as one element
            last_index <= (SIZE_IN == word_zero) ? word_zero : SIZE_IN - word_one;
            index_loop <= word_zero;
            state      <= input_state;
          end
        end
        input_state: begin
          if (DATA_IN_ENABLE) begin
            // Scalar start for every element
            start_scalar <= 1'b1;
            state        <= ender_state;
          end
        end
        ender_state: begin
          if (ready_scalar) begin
            DATA_OUT        <= result_scalar;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_loop == last_index) begin
              // Last result
              READY <= 1'b1;
              state <= starter_state;
            end else begin
              index_loop <= index_loop + word_one;
              state      <= input_state;
            end
          end
        end
        default: begin
          state <= starter_state;
        end
      endcase
    end
  end

  // Operand capture, stable while the scalar inverter runs
  always_ff @(posedge CLK) begin
    if (state == input_state && DATA_IN_ENABLE) begin
      modulo_scalar <= MODULO_IN;
      data_scalar   <= DATA_IN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scalar inverter
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_inverter scalar_inverter (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start_scalar),
    .modulo_in (modulo_scalar),
    .data_in   (data_scalar),
    .ready     (ready_scalar),
    .data_out  (result_scalar)
  );

endmodule

`default_nettype wire

// ==== src/ntm_inverter_top.sv ====
/*
 * Top level of the modular inverter
 *   Subsystem boundary for the accelerator
 *   Vector sequencer with its scalar inverter
 */

`timescale 1ns/10ps
`default_nettype none

module ntm_inverter_top
  import ntm_inverter_pkg::*;
(
  // Global
  input  wire                  CLK,
  input  wire                  RST,

  // Control
  input  wire                  START,
  input  wire                  DATA_IN_ENABLE,
  output logic                 READY,
  output logic                 DATA_OUT_ENABLE,

  // Data
  input  wire  [data_size-1:0] SIZE_IN,
  input  wire  [data_size-1:0] MODULO_IN,
  input  wire  [data_size-1:0] DATA_IN,
  output logic [data_size-1:0] DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Vector sequencer
  //////////////////////////////////////////////////////////////////////

  // No registers here, latency is the sequencer's
  ntm_vector_inverter vector_inverter (
    // Global
    .CLK             (CLK),
    .RST             (RST),

    // Control
    .START           (START),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),

    // Data
    .SIZE_IN         (SIZE_IN),
    .MODULO_IN       (MODULO_IN),
    .DATA_IN         (DATA_IN),
    .DATA_OUT        (DATA_OUT)
  );

endmodule

`default_nettype wire

// ==== test/ntm_inverter_tb.sv ====
/*
 * Testbench of the modular inverter
 *   Clock, reset and trace-driven stimulus
 *   Result, strobe count and READY checks per vector
 *   Random elements checked by their product with the result
 */

`timescale 1ns/10ps
`default_nettype none

module ntm_inverter_tb
  import ntm_inverter_pkg::*;
();

  // Cycles allowed for one result
  localparam int wait_limit = 200;

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 DATA_IN_ENABLE;
  logic [data_size-1:0] SIZE_IN;
  logic [data_size-1:0] MODULO_IN;
  logic [data_size-1:0] DATA_IN;
  logic                 READY;
  logic                 DATA_OUT_ENABLE;
  logic [data_size-1:0] DATA_OUT;

  // Output monitor
  int                   strobe_total;
  int                   ready_total;
  int                   vector_base;
  int                   vector_len;
  logic [data_size-1:0] last_result;

  // Trace contents
  int                   fd;
  logic [data_size-1:0] primes[$];
  logic [data_size-1:0] elem_mod[$];
  logic [data_size-1:0] elem_op[$];
  logic [data_size-1:0] elem_exp[$];

  ntm_inverter_top dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .SIZE_IN         (SIZE_IN),
    .MODULO_IN       (MODULO_IN),
    .DATA_IN         (DATA_IN),
    .DATA_OUT        (DATA_OUT)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s actual %h expected %h", name, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle stepping
  //////////////////////////////////////////////////////////////////////

  // Outputs sampled and inputs driven 0.5 ns after the edge
  task automatic step_cycle();
    @(posedge CLK);
    #0.5;
    if (DATA_OUT_ENABLE) begin
      strobe_total = strobe_total + 1;
      last_result  = DATA_OUT;
    end
    if (READY) begin
      ready_total = ready_total + 1;
      // Only together with the last strobe of the vector
      check_value("READY strobe index", 64'(strobe_total - vector_base), 64'(vector_len));
      check_value("DATA_OUT_ENABLE at READY", 64'(DATA_OUT_ENABLE), 64'd1);
    end
  endtask

  task automatic wait_result();
    int            start_count;
    vector_state_t fsm_state;
    start_count = strobe_total;
    for (int i = 0; i < wait_limit; i++) begin
      step_cycle();
      if (strobe_total != start_count) begin
        return;
      end
    end
    // Sequencer state helps when debugging a hang
    fsm_state = dut.vector_inverter.state;
    $display("Sequencer state at timeout %s", fsm_state.name());
    abort_run("DATA_OUT_ENABLE never came within the wait limit");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic send_element(input logic [data_size-1:0] modulo,
                              input logic [data_size-1:0] operand, input bit disturb);
    MODULO_IN      = modulo;
    DATA_IN        = operand;
    DATA_IN_ENABLE = 1'b1;
    step_cycle();
    DATA_IN_ENABLE = 1'b0;
    if (disturb) begin
      // Stray element and START while the result is pending
      MODULO_IN      = 9;
      DATA_IN        = 3;
      SIZE_IN        = 2;
      DATA_IN_ENABLE = 1'b1;
      START          = 1'b1;
      step_cycle();
      DATA_IN_ENABLE = 1'b0;
      START          = 1'b0;
    end
    wait_result();
  endtask

  task automatic run_vector(input logic [data_size-1:0] size, input bit disturb,
                            input bit product_check);
    logic [63:0] product;
    int          ready_base;
    // No strobe left over from the previous vector
    check_value("DATA_OUT_ENABLE count", 64'(strobe_total), 64'(vector_base + vector_len));
    vector_base = strobe_total;
    vector_len  = (size == 0) ? 1 : int'(size);
    ready_base  = ready_total;
    START       = 1'b1;
    SIZE_IN     = size;
    step_cycle();
    START       = 1'b0;
    for (int k = 0; k < elem_op.size(); k++) begin
      send_element(elem_mod[k], elem_op[k], disturb);
      check_value("DATA_OUT_ENABLE index", 64'(strobe_total - vector_base), 64'(k + 1));
      if (product_check) begin
        product = (64'(elem_op[k]) * 64'(last_result)) % 64'(elem_mod[k]);
        check_value("DATA_IN * DATA_OUT mod MODULO_IN", product, 64'd1);
      end else begin
        check_value("DATA_OUT", 64'(last_result), 64'(elem_exp[k]));
      end
      if (disturb && k + 1 < elem_op.size()) begin
        // START between two elements
        START   = 1'b1;
        SIZE_IN = 1;
        step_cycle();
        START   = 1'b0;
      end
    end
    check_value("READY count", 64'(ready_total - ready_base), 64'd1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace reading
  //////////////////////////////////////////////////////////////////////

  // Next line that is neither blank nor a comment
  task automatic next_record(output string line);
    int code;
    line = "";
    while (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n" ||
           line.getc(0) == "\r") begin
      code = $fgets(line, fd);
      if (code == 0) begin
        abort_run("Trace file ended without its end marker");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    string                line;
    string                fields;
    logic [data_size-1:0] a;
    logic [data_size-1:0] b;
    logic [data_size-1:0] c;
    logic [data_size-1:0] m;
    int unsigned          idx;
    int                   code;
    bit                   done;
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    DATA_IN_ENABLE = 1'b0;
    SIZE_IN        = '0;
    MODULO_IN      = '0;
    DATA_IN        = '0;
    strobe_total   = 0;
    ready_total    = 0;
    vector_base    = 0;
    vector_len     = 0;
    last_result    = '0;
    void'($urandom(32'h5b4e));

    // Four reset cycles and the one after release
    for (int i = 0; i < 5; i++) begin
      step_cycle();
      check_value("READY", 64'(READY), 64'd0);
      check_value("DATA_OUT_ENABLE", 64'(DATA_OUT_ENABLE), 64'd0);
      check_value("DATA_OUT", 64'(DATA_OUT), 64'd0);
      if (i == 3) begin
        RST = 1'b0;
      end
    end

    fd = $fopen("test/ntm_inverter_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the trace file test/ntm_inverter_trace.txt");
    end
    done = 1'b0;
    while (!done) begin
      next_record(line);
      fields = line.substr(1, line.len() - 1);
      elem_mod.delete();
      elem_op.delete();
      elem_exp.delete();
      case (line.getc(0))
        "V": begin
          code = $sscanf(fields, "%h %h", a, b);
          if (code != 2) begin
            abort_run("Malformed vector header in the trace");
          end
          // Zero length still carries one element
          for (int k = 0; k < ((b == 0) ? 1 : int'(b)); k++) begin
            next_record(line);
            fields = line.substr(1, line.len() - 1);
            if (line.getc(0) != "D" || $sscanf(fields, "%h %h", m, c) != 2) begin
              abort_run("Vector in the trace has too few element lines");
            end
            elem_mod.push_back(a);
            elem_op.push_back(m);
            elem_exp.push_back(c);
          end
          run_vector(b, 1'b0, 1'b0);
        end
        "S": begin
          // Same as V with stray strobes
          code = $sscanf(fields, "%h %h", a, b);
          if (code != 2) begin
            abort_run("Malformed vector header in the trace");
          end
          for (int k = 0; k < ((b == 0) ? 1 : int'(b)); k++) begin
            next_record(line);
            fields = line.substr(1, line.len() - 1);
            if (line.getc(0) != "D" || $sscanf(fields, "%h %h", m, c) != 2) begin
              abort_run("Vector in the trace has too few element lines");
            end
            elem_mod.push_back(a);
            elem_op.push_back(m);
            elem_exp.push_back(c);
          end
          run_vector(b, 1'b1, 1'b0);
        end
        "P": begin
          if ($sscanf(fields, "%h", a) != 1) begin
            abort_run("Malformed prime line in the trace");
          end
          primes.push_back(a);
        end
        "R": begin
          if ($sscanf(fields, "%h", a) != 1 || primes.size() == 0 || a == 0) begin
            abort_run("Random run in the trace lacks a count or a prime");
          end
          // Random prime per element and operand in 1 .. m-1
          for (int k = 0; k < int'(a); k++) begin
            idx = $urandom % 32'(primes.size());
            m   = primes[idx];
            elem_mod.push_back(m);
            elem_op.push_back(($urandom % (m - 1)) + 1);
          end
          run_vector(a, 1'b0, 1'b1);
        end
        "Q": begin
          done = 1'b1;
        end
        default: begin
          abort_run("Unknown record kind in the trace");
        end
      endcase
    end
    $fclose(fd);

    // Idle tail catches a late strobe
    for (int i = 0; i < 4; i++) begin
      step_cycle();
    end
    check_value("DATA_OUT_ENABLE count", 64'(strobe_total), 64'(vector_base + vector_len));
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/ntm_inverter_trace.txt ====
# V modulus length, or S with stray strobes; then per element D operand expected (hex)
# Length 0 still sends one element. P prime for random runs, R random run length, Q end
V 7 6
D 1 1
D 2 4
D 3 5
D 4 2
D 5 3
D 6 6
# Shared factors and zero
V 9 5
D 3 0
D 0 0
D 2 5
D 6 0
D 4 7
V 15 3
D e 0
D 7 0
D 8 8
V d 0
D 5 8
S f 4
D 2 8
D 7 d
D 5 0
D e e
V 3b9aca07 5
D 1 1
D 2 1dcd6504
D 3 13de4358
D 3b9aca06 3b9aca06
D 0 0
S fffffffb 3
D 2 7ffffffe
D fffffffa fffffffa
D 1 1
P 3b9aca07
P 7fffffff
P fffffffb
P 3b800001
R 8
R 5
Q

// ==== flist.f ====
src/ntm_inverter_pkg.sv
src/ntm_scalar_inverter.sv
src/ntm_vector_inverter.sv
src/ntm_inverter_top.sv
test/ntm_inverter_tb.sv

// ==== Makefile ====
# Verilator build and run of the modular inverter testbench

VERILATOR ?= verilator
TOP       ?= ntm_inverter_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ** PASS **
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG PASS_TEXT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
